// ==== logic/ctrl_pipe.sv ====
/*
 * Control pipeline
 * Carries decoded controls through execute, memory and write-back,
 * inserting bubbles for hazards and flushes and freezing on stall
 */
`timescale 1ns/1ps
`default_nettype none

module ctrl_pipe import cu_pkg::*; (
	input  logic        clk,
	input  logic        nrst,
	input  stage_ctrl_t ctrl,
	input  logic        bubble,
	input  logic        stall,
	input  logic        chng2nop,
	output ex_ctrl_t    ex_ctrl,
	output mem_ctrl_t   mem_ctrl,
	output wb_ctrl_t    wb_ctrl
);

	// Controls still needed once the instruction leaves execute
	typedef struct packed {
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} mem_stage_t;

	stage_ctrl_t ex_q;
	mem_stage_t  mem_q;
	wb_ctrl_t    wb_q;
	logic        kill;

	// Hazard bubble or mispredict flush
	assign kill = bubble || chng2nop;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			ex_q  <= '0;
			mem_q <= '0;
			wb_q  <= '0;
		end else if (!stall) begin
			ex_q <= kill ? stage_ctrl_t'('0) : ctrl;
			mem_q.mem <= ex_q.mem;
			mem_q.wb  <= ex_q.wb;
			wb_q <= mem_q.wb;
		end
	end

	assign ex_ctrl  = ex_q.ex;
	assign mem_ctrl = mem_q.mem;
	assign wb_ctrl  = wb_q;

endmodule

`default_nettype wire

// ==== logic/cu_csr.sv ====
/*
 * Hazard configuration register block
 * AXI4-Lite slave holding the hazard enable, the load-branch bubble count
 * and saturating counters for inserted bubbles and stall cycles
 */
`timescale 1ns/1ps
`default_nettype none

module cu_csr import cu_pkg::*; #(
	parameter int cnt_w = 16
) (
	input  logic                clk,
	input  logic                nrst,
	input  logic [AXI_AW-1:0]   awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  logic [AXI_DW-1:0]   wdata,
	input  logic [AXI_DW/8-1:0] wstrb,
	input  logic                wvalid,
	output logic                wready,
	output logic [1:0]          bresp,
	output logic                bvalid,
	input  logic                bready,
	input  logic [AXI_AW-1:0]   araddr,
	input  logic                arvalid,
	output logic                arready,
	output logic [AXI_DW-1:0]   rdata,
	output logic [1:0]          rresp,
	output logic                rvalid,
	input  logic                rready,
	input  logic                bubble_pulse,
	input  logic                stall_pulse,
	output hz_cfg_t             cfg
);

	logic             wr_fire;
	logic             rd_fire;
	logic [cnt_w-1:0] bubble_cnt;
	logic [cnt_w-1:0] stall_cyc;
	logic [AXI_DW-1:0] rd_mux;

	function automatic logic [cnt_w-1:0] sat_inc(input logic [cnt_w-1:0] v);
		return (&v) ? v : v + 1'b1;    // Stick at all ones
	endfunction

	// Address and data are taken together, one response outstanding
	assign wr_fire = awvalid && wvalid && !bvalid;
	assign awready = wr_fire;
	assign wready  = wr_fire;
	assign bresp   = RESP_OKAY;

	assign rd_fire = arvalid && !rvalid;
	assign arready = !rvalid;
	assign rresp   = RESP_OKAY;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			cfg    <= '{hz_en: 1'b1, ld_br_delay: LD_BR_DELAY_RST};
			bvalid <= 1'b0;
		end else begin
			if (wr_fire && awaddr == CFG_ADDR && wstrb[0]) begin
				cfg.hz_en       <= wdata[0];
				cfg.ld_br_delay <= wdata[6:4];
			end
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	// Any write to a counter address clears it
	always_ff @(posedge clk) begin
		if (!nrst) begin
			bubble_cnt <= '0;
			stall_cyc  <= '0;
		end else begin
			if (wr_fire && awaddr == BUBBLE_CNT_ADDR)
				bubble_cnt <= '0;
			else if (bubble_pulse)
				bubble_cnt <= sat_inc(bubble_cnt);
			if (wr_fire && awaddr == STALL_CYC_ADDR)
				stall_cyc <= '0;
			else if (stall_pulse)
				stall_cyc <= sat_inc(stall_cyc);
		end
	end

	always_comb begin
		rd_mux = '0;    // Unmapped reads return zero
		case (araddr)
			CFG_ADDR: begin
				rd_mux[0]   = cfg.hz_en;
				rd_mux[6:4] = cfg.ld_br_delay;
			end
			BUBBLE_CNT_ADDR: rd_mux = AXI_DW'(bubble_cnt);
			STALL_CYC_ADDR:  rd_mux = AXI_DW'(stall_cyc);
			default:         rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!nrst)
			rvalid <= 1'b0;
		else if (rd_fire)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rd_fire)
			rdata <= rd_mux;
	end

endmodule

`default_nettype wire

// ==== logic/cu_pkg.sv ====
/*
 * RV32I decode control unit package
 * Opcodes, funct3 codes, ALU operations, instruction views,
 * per-stage control structs and the AXI4-Lite register map
 */
`default_nettype none

package cu_pkg;

	localparam int AXI_AW = 4;
	localparam int AXI_DW = 32;
	localparam int REG_W  = 5;     // Register index width

	// RV32I major opcodes
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_FENCE  = 7'b0001111     // Handled with R-type control
	} opcode_e;

	// funct3 for op and op_imm
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRX     = 3'b101;    // SRL or SRA by funct7 bit 30
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	typedef enum logic [3:0] {
		ALU_PASS, ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
	} alu_op_e;

	typedef struct packed {
		logic [6:0]       funct7;
		logic [REG_W-1:0] rs2;
		logic [REG_W-1:0] rs1;
		logic [2:0]       funct3;
		logic [REG_W-1:0] rd;
		logic [6:0]       opcode;
	} r_fmt_t;

	// Stores and branches carry immediate bits where rd would be
	typedef struct packed {
		logic [6:0]       imm_hi;
		logic [REG_W-1:0] rs2;
		logic [REG_W-1:0] rs1;
		logic [2:0]       funct3;
		logic [4:0]       imm_lo;
		logic [6:0]       opcode;
	} s_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		s_fmt_t s_fmt;
	} instr_u;

	typedef struct packed {
		logic    reg_a_en;
		logic    reg_b_en;
		logic    imm_en;
		logic    mux_a_sel;    // 0 PC, 1 register A
		logic    mux_b_sel;    // 0 register B, 1 immediate
		alu_op_e alu_op;
		logic    valid;
	} ex_ctrl_t;

	typedef struct packed {
		logic dram_we;
		logic dram_re;
		logic valid;
	} mem_ctrl_t;

	typedef struct packed {
		logic mux_c_sel;
		logic mux_d_sel;
		logic rf_we;
		logic valid;
	} wb_ctrl_t;

	typedef struct packed {
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} stage_ctrl_t;

	typedef struct packed {
		logic       hz_en;
		logic [2:0] ld_br_delay;    // Bubbles for load then dependent branch
	} hz_cfg_t;

	// Register map, CFG holds hz_en in bit 0 and ld_br_delay in bits 6:4
	localparam logic [AXI_AW-1:0] CFG_ADDR        = 4'h0;
	localparam logic [AXI_AW-1:0] BUBBLE_CNT_ADDR = 4'h4;
	localparam logic [AXI_AW-1:0] STALL_CYC_ADDR  = 4'h8;
	localparam logic [2:0]        LD_BR_DELAY_RST = 3'd2;
	localparam logic [1:0]        RESP_OKAY       = 2'b00;

endpackage

`default_nettype wire

// ==== logic/cu_top.sv ====
/*
 * Decode-side control unit top
 * Decoder, hazard unit, stage control pipeline and AXI4-Lite registers
 */
`timescale 1ns/1ps
`default_nettype none

module cu_top import cu_pkg::*; #(
	parameter int cnt_w = 16
) (
	input  logic                clk,
	input  logic                nrst,
	input  instr_u              instr,
	input  logic                stall,
	input  logic                chng2nop,
	output logic                pc_en,
	output logic                fd_en,
	output ex_ctrl_t            ex_ctrl,
	output mem_ctrl_t           mem_ctrl,
	output wb_ctrl_t            wb_ctrl,
	input  logic [AXI_AW-1:0]   awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  logic [AXI_DW-1:0]   wdata,
	input  logic [AXI_DW/8-1:0] wstrb,
	input  logic                wvalid,
	output logic                wready,
	output logic [1:0]          bresp,
	output logic                bvalid,
	input  logic                bready,
	input  logic [AXI_AW-1:0]   araddr,
	input  logic                arvalid,
	output logic                arready,
	output logic [AXI_DW-1:0]   rdata,
	output logic [1:0]          rresp,
	output logic                rvalid,
	input  logic                rready
);

	stage_ctrl_t      dec_ctrl;
	logic [REG_W-1:0] rs1, rs2, rd;
	logic             is_load, is_branch;
	logic             bubble, bubble_pulse, stall_pulse;
	hz_cfg_t          cfg;

	instr_decode decode_i (
		.instr(instr), .ctrl(dec_ctrl), .rs1(rs1), .rs2(rs2), .rd(rd),
		.is_load(is_load), .is_branch(is_branch)
	);

	hazard_unit hazard_i (
		.clk(clk), .nrst(nrst), .stall(stall), .cfg(cfg),
		.rs1(rs1), .rs2(rs2), .rd(rd), .is_load(is_load), .is_branch(is_branch),
		.bubble(bubble), .pc_en(pc_en), .fd_en(fd_en),
		.bubble_pulse(bubble_pulse), .stall_pulse(stall_pulse)
	);

	ctrl_pipe pipe_i (
		.clk(clk), .nrst(nrst), .ctrl(dec_ctrl), .bubble(bubble), .stall(stall),
		.chng2nop(chng2nop), .ex_ctrl(ex_ctrl), .mem_ctrl(mem_ctrl), .wb_ctrl(wb_ctrl)
	);

	cu_csr #(.cnt_w(cnt_w)) csr_i (
		.clk(clk), .nrst(nrst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.bubble_pulse(bubble_pulse), .stall_pulse(stall_pulse), .cfg(cfg)
	);

endmodule

`default_nettype wire

// ==== logic/hazard_unit.sv ====
/*
 * Hazard unit
 * Compares decode operands with the instruction that last entered execute
 * and times load-use, writer-branch and load-branch bubbles
 */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cu_pkg::*; (
	input  logic             clk,
	input  logic             nrst,
	input  logic             stall,
	input  hz_cfg_t          cfg,
	input  logic [REG_W-1:0] rs1,
	input  logic [REG_W-1:0] rs2,
	input  logic [REG_W-1:0] rd,
	input  logic             is_load,
	input  logic             is_branch,
	output logic             bubble,
	output logic             pc_en,
	output logic             fd_en,
	output logic             bubble_pulse,
	output logic             stall_pulse
);

	logic [REG_W-1:0] prev_rd;     // Destination of the instruction in execute
	logic             prev_ld;
	logic [2:0]       hold_cnt;    // Bubbles still owed after this cycle
	logic [2:0]       hz_len;
	logic [2:0]       remaining;
	logic             active;

	// Bubble count required by the current pair
	always_comb begin
		hz_len = 3'd0;
		if (cfg.hz_en && prev_rd != '0 && (rs1 == prev_rd || rs2 == prev_rd)) begin
			if (prev_ld && is_branch)
				hz_len = cfg.ld_br_delay;
			else if (prev_ld || is_branch)
				hz_len = 3'd1;
		end
	end

	assign active    = (hold_cnt != 3'd0) || (hz_len != 3'd0);
	assign remaining = (hold_cnt != 3'd0) ? hold_cnt - 3'd1 : hz_len - 3'd1;

	assign bubble       = active;
	assign pc_en        = !stall && !active;
	assign fd_en        = !stall && !active;
	assign bubble_pulse = active && !stall;
	assign stall_pulse  = stall;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			prev_rd  <= '0;
			prev_ld  <= 1'b0;
			hold_cnt <= 3'd0;
		end else if (!stall) begin
			if (!active) begin
				prev_rd  <= rd;    // Decode instruction moves into execute
				prev_ld  <= is_load;
				hold_cnt <= 3'd0;
			end else begin
				hold_cnt <= remaining;
				// Record stays frozen until the last bubble goes in
				if (remaining == 3'd0) begin
					prev_rd <= '0;
					prev_ld <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/instr_decode.sv ====
/*
 * Instruction decoder
 * Maps one RV32I instruction to its stage control word and ALU operation,
 * and extracts the register fields used for hazard detection
 */
`timescale 1ns/1ps
`default_nettype none

module instr_decode import cu_pkg::*; (
	input  instr_u            instr,
	output stage_ctrl_t       ctrl,
	output logic [REG_W-1:0]  rs1,
	output logic [REG_W-1:0]  rs2,
	output logic [REG_W-1:0]  rd,
	output logic              is_load,
	output logic              is_branch
);

	opcode_e op;
	alu_op_e alu_fn;

	// en is {reg_a, reg_b, imm}, mux is {a, b}, mem is {we, re}, wb is {c, d, rf_we}
	function automatic stage_ctrl_t pack_ctrl(input logic [2:0] en, input logic [1:0] mux,
			input alu_op_e alu, input logic [1:0] mem, input logic [2:0] wb);
		stage_ctrl_t c;
		c.ex  = '{reg_a_en: en[2], reg_b_en: en[1], imm_en: en[0],
			mux_a_sel: mux[1], mux_b_sel: mux[0], alu_op: alu, valid: 1'b1};
		c.mem = '{dram_we: mem[1], dram_re: mem[0], valid: 1'b1};
		c.wb  = '{mux_c_sel: wb[2], mux_d_sel: wb[1], rf_we: wb[0], valid: 1'b1};
		return c;
	endfunction

	assign op        = opcode_e'(instr.r_fmt.opcode);
	assign is_load   = (op == OPC_LOAD);
	assign is_branch = (op == OPC_BRANCH);

	// Bit 30 selects SUB only for the register form
	always_comb begin
		case (instr.r_fmt.funct3)
			F3_ADD_SUB: alu_fn = (instr.r_fmt.funct7[5] && op == OPC_OP) ? ALU_SUB : ALU_ADD;
			F3_SLL:     alu_fn = ALU_SLL;
			F3_SLT:     alu_fn = ALU_SLT;
			F3_SLTU:    alu_fn = ALU_SLTU;
			F3_XOR:     alu_fn = ALU_XOR;
			F3_SRX:     alu_fn = instr.r_fmt.funct7[5] ? ALU_SRA : ALU_SRL;
			F3_OR:      alu_fn = ALU_OR;
			default:    alu_fn = ALU_AND;
		endcase
	end

	always_comb begin
		case (op)
			OPC_AUIPC:  ctrl = pack_ctrl(3'b001, 2'b01, ALU_ADD, 2'b00, 3'b101);
			OPC_LUI:    ctrl = pack_ctrl(3'b001, 2'b11, ALU_PASS, 2'b00, 3'b101);
			OPC_BRANCH: ctrl = pack_ctrl(3'b111, 2'b11, ALU_SUB, 2'b00, 3'b100);
			OPC_JAL:    ctrl = pack_ctrl(3'b001, 2'b10, ALU_ADD, 2'b00, 3'b111);
			OPC_JALR:   ctrl = pack_ctrl(3'b101, 2'b01, ALU_ADD, 2'b00, 3'b111);
			OPC_LOAD:   ctrl = pack_ctrl(3'b101, 2'b11, ALU_ADD, 2'b01, 3'b001);
			OPC_STORE:  ctrl = pack_ctrl(3'b111, 2'b11, ALU_ADD, 2'b10, 3'b100);
			OPC_OP_IMM: ctrl = pack_ctrl(3'b101, 2'b11, alu_fn, 2'b00, 3'b101);
			OPC_OP:     ctrl = pack_ctrl(3'b110, 2'b10, alu_fn, 2'b00, 3'b101);
			OPC_FENCE:  ctrl = pack_ctrl(3'b110, 2'b10, ALU_PASS, 2'b00, 3'b101);
			default:    ctrl = '0;    // Unknown opcode decodes to a bubble
		endcase
	end

	// Operand fields, zeroed where the format has none
	always_comb begin
		rs1 = instr.r_fmt.rs1;
		rs2 = instr.r_fmt.rs2;
		rd  = instr.r_fmt.rd;
		case (op)
			OPC_LUI, OPC_AUIPC, OPC_JAL: begin
				rs1 = '0;
				rs2 = '0;
			end
			OPC_JALR, OPC_LOAD, OPC_OP_IMM: rs2 = '0;
			OPC_STORE, OPC_BRANCH: begin
				rs1 = instr.s_fmt.rs1;
				rs2 = instr.s_fmt.rs2;
				rd  = '0;    // imm_lo, not a destination
			end
			OPC_OP, OPC_FENCE: begin
				rd = instr.r_fmt.rd;
			end
			default: begin
				rs1 = '0;
				rs2 = '0;
				rd  = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== verif/cu_tb.sv ====
/*
 * Testbench for the decode-side control unit
 * Drives instruction streams and AXI4-Lite accesses, and checks the stage
 * controls, fetch hold and counters against a reference model
 */
`timescale 1ns/1ps
`default_nettype none

module cu_tb import cu_pkg::*; ;

	localparam int cnt_w       = 16;
	localparam int test_cycles = 1500;    // Random run dominates, up to ~6 cycles per instruction
	localparam int max_cycles  = test_cycles + 200;

	typedef struct packed {
		logic [REG_W-1:0] rs1;
		logic [REG_W-1:0] rs2;
		logic [REG_W-1:0] rd;
		logic             ld;
		logic             br;
	} fields_t;

	logic                clk;
	logic                nrst;
	instr_u              instr;
	logic                stall;
	logic                chng2nop;
	logic                pc_en;
	logic                fd_en;
	ex_ctrl_t            ex_ctrl;
	mem_ctrl_t           mem_ctrl;
	wb_ctrl_t            wb_ctrl;
	logic [AXI_AW-1:0]   awaddr;
	logic                awvalid;
	logic                awready;
	logic [AXI_DW-1:0]   wdata;
	logic [AXI_DW/8-1:0] wstrb;
	logic                wvalid;
	logic                wready;
	logic [1:0]          bresp;
	logic                bvalid;
	logic                bready;
	logic [AXI_AW-1:0]   araddr;
	logic                arvalid;
	logic                arready;
	logic [AXI_DW-1:0]   rdata;
	logic [1:0]          rresp;
	logic                rvalid;
	logic                rready;

	int          seed = 32'hf020e279;
	int          errors = 0;
	int          checks = 0;
	int          test_base = 0;
	int          n_tests = 0;
	int          cycles = 0;
	int          m_bub = 0;     // Model bubble count
	int          m_stl = 0;     // Model stall cycles
	int          pcl = 0;       // Observed cycles with pc_en low, no stall
	hz_cfg_t     m_cfg = '{hz_en: 1'b1, ld_br_delay: 3'd2};
	logic [4:0]  m_prev_rd;
	logic        m_prev_ld;
	logic [2:0]  m_hold;
	stage_ctrl_t pipe_q[$];     // Expected ex, mem, wb words

	cu_top #(.cnt_w(cnt_w)) dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic instr_u enc(input logic [6:0] opc, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2, input logic [2:0] f3,
			input logic [6:0] f7);
		return instr_u'({f7, rs2, rs1, f3, rd, opc});
	endfunction

	// Expected controls from the opcode table
	function automatic stage_ctrl_t ref_ctrl(input instr_u i);
		logic [13:0] code;    // {en a b imm, mux a b, alu, dram we re, wb c d we}
		alu_op_e     a;
		logic [6:0]  opc;
		stage_ctrl_t c;
		opc = i.r_fmt.opcode;
		case (i.r_fmt.funct3)
			3'd0: a = (i.r_fmt.funct7[5] && opc == OPC_OP) ? ALU_SUB : ALU_ADD;
			3'd1: a = ALU_SLL;
			3'd2: a = ALU_SLT;
			3'd3: a = ALU_SLTU;
			3'd4: a = ALU_XOR;
			3'd5: a = i.r_fmt.funct7[5] ? ALU_SRA : ALU_SRL;
			3'd6: a = ALU_OR;
			default: a = ALU_AND;
		endcase
		case (opc)
			OPC_LUI:    code = {3'b001, 2'b11, ALU_PASS, 2'b00, 3'b101};
			OPC_AUIPC:  code = {3'b001, 2'b01, ALU_ADD, 2'b00, 3'b101};
			OPC_JAL:    code = {3'b001, 2'b10, ALU_ADD, 2'b00, 3'b111};
			OPC_JALR:   code = {3'b101, 2'b01, ALU_ADD, 2'b00, 3'b111};
			OPC_BRANCH: code = {3'b111, 2'b11, ALU_SUB, 2'b00, 3'b100};
			OPC_LOAD:   code = {3'b101, 2'b11, ALU_ADD, 2'b01, 3'b001};
			OPC_STORE:  code = {3'b111, 2'b11, ALU_ADD, 2'b10, 3'b100};
			OPC_OP_IMM: code = {3'b101, 2'b11, a, 2'b00, 3'b101};
			OPC_OP:     code = {3'b110, 2'b10, a, 2'b00, 3'b101};
			OPC_FENCE:  code = {3'b110, 2'b10, ALU_PASS, 2'b00, 3'b101};
			default:    return '0;
		endcase
		c.ex  = ex_ctrl_t'({code[13:5], 1'b1});
		c.mem = mem_ctrl_t'({code[4:3], 1'b1});
		c.wb  = wb_ctrl_t'({code[2:0], 1'b1});
		return c;
	endfunction

	// Operand fields by format
	function automatic fields_t ref_fields(input instr_u i);
		fields_t f;
		logic [6:0] opc;
		opc = i.r_fmt.opcode;
		f = '{rs1: i.r_fmt.rs1, rs2: i.r_fmt.rs2, rd: i.r_fmt.rd,
			ld: opc == OPC_LOAD, br: opc == OPC_BRANCH};
		if (opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL})
			f.rs1 = '0;
		if (opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD, OPC_OP_IMM})
			f.rs2 = '0;
		if (opc inside {OPC_STORE, OPC_BRANCH})
			f.rd = '0;
		if (!(opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
				OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_FENCE}))
			f = '0;
		return f;
	endfunction

	task automatic check_ex(input string name, input ex_ctrl_t got, input ex_ctrl_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_mem(input string name, input mem_ctrl_t got, input mem_ctrl_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_wb(input string name, input wb_ctrl_t got, input wb_ctrl_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input logic [cnt_w-1:0] got,
			input logic [cnt_w-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Reference pipeline and hazard model, compared every edge
	always @(posedge clk) begin
		fields_t     f;
		logic [2:0]  len;
		logic        bub;
		stage_ctrl_t nxt;
		if (!nrst) begin
			m_prev_rd = '0;
			m_prev_ld = 1'b0;
			m_hold    = '0;
			pipe_q    = '{stage_ctrl_t'('0), stage_ctrl_t'('0), stage_ctrl_t'('0)};
		end else begin
			check_ex("ex_ctrl", ex_ctrl, pipe_q[0].ex);
			check_mem("mem_ctrl", mem_ctrl, pipe_q[1].mem);
			check_wb("wb_ctrl", wb_ctrl, pipe_q[2].wb);
			f   = ref_fields(instr);
			len = 3'd0;
			if (m_cfg.hz_en && m_prev_rd != 0 && (f.rs1 == m_prev_rd || f.rs2 == m_prev_rd)) begin
				if (m_prev_ld && f.br)
					len = m_cfg.ld_br_delay;
				else if (m_prev_ld || f.br)
					len = 3'd1;
			end
			bub = (m_hold != 0) || (len != 0);
			check_word("pc_en", cnt_w'(pc_en), cnt_w'(!stall && !bub));
			check_word("fd_en", cnt_w'(fd_en), cnt_w'(!stall && !bub));
			if (!stall && !pc_en)
				pcl++;
			if (stall) begin
				m_stl++;
			end else begin
				if (bub) begin
					m_bub++;
					nxt = '0;
					if (m_hold != 0)
						m_hold = m_hold - 3'd1;
					else
						m_hold = len - 3'd1;
					if (m_hold == 0) begin
						m_prev_rd = '0;
						m_prev_ld = 1'b0;
					end
				end else begin
					nxt = chng2nop ? stage_ctrl_t'('0) : ref_ctrl(instr);
					m_prev_rd = f.rd;
					m_prev_ld = f.ld;
				end
				pipe_q.push_front(nxt);
				void'(pipe_q.pop_back());
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("Run timed out after %0d cycles", cycles);
			$display("Errors found");
			$finish;
		end
	end

	// Present one instruction and wait until fetch moves on
	task automatic send(input instr_u w, input int nstall, input logic flush);
		instr    <= w;
		chng2nop <= flush;
		if (nstall > 0) begin
			stall <= 1'b1;
			repeat (nstall) @(posedge clk);
			stall <= 1'b0;
		end
		@(posedge clk);
		while (!pc_en)
			@(posedge clk);
		instr    <= '0;
		chng2nop <= 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) send('0, 0, 1'b0);
	endtask

	task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [31:0] data);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		@(posedge clk);
		while (!awready)
			@(posedge clk);
		check_word("wready", cnt_w'(wready), cnt_w'(1'b1));
		// Model takes the new setting from the next edge, as the DUT does
		if (addr == CFG_ADDR)
			m_cfg <= '{hz_en: data[0], ld_br_delay: data[6:4]};
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		bready  <= 1'b1;
		@(posedge clk);
		while (!bvalid)
			@(posedge clk);
		check_word("bresp", cnt_w'(bresp), '0);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [31:0] data);
		araddr  <= addr;
		arvalid <= 1'b1;
		@(posedge clk);
		while (!arready)
			@(posedge clk);
		arvalid <= 1'b0;
		rready  <= 1'b1;
		@(posedge clk);
		while (!rvalid)
			@(posedge clk);
		data = rdata;
		check_word("rresp", cnt_w'(rresp), '0);
		rready <= 1'b0;
	endtask

	task automatic finish_test(input string name);
		$display("%s: %0d errors", name, errors - test_base);
		test_base = errors;
		n_tests++;
	endtask

	// Clear the bubble counter, run a pair, then compare counter and hold cycles
	task automatic hazard_pair(input instr_u a, input instr_u b, input int exp);
		logic [31:0] d;
		int          base;
		axi_write(BUBBLE_CNT_ADDR, 32'h0);
		base = pcl;
		send(a, 0, 1'b0);
		send(b, 0, 1'b0);
		idle(2);
		axi_read(BUBBLE_CNT_ADDR, d);
		check_word("bubble_cnt", d[cnt_w-1:0], cnt_w'(exp));
		check_word("pc_en low cycles", cnt_w'(pcl - base), cnt_w'(exp));
	endtask

	function automatic instr_u rand_instr();
		opcode_e opc_list[9] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
			OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP};
		logic [31:0] r;
		r = $random(seed);
		return enc(opc_list[$unsigned($random(seed)) % 9], {3'b0, r[1:0]}, {3'b0, r[3:2]},
			{3'b0, r[5:4]}, r[8:6], {1'b0, r[9], 5'b0});    // Few registers so hazards are common
	endfunction

	initial begin
		logic [31:0] d;
		int          bub_base;
		int          stl_base;
		int          n;
		nrst = 1'b0;
		instr = '0;
		stall = 1'b0;
		chng2nop = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hf;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (16) @(posedge clk);
		nrst <= 1'b1;
		@(posedge clk);

		axi_read(CFG_ADDR, d);
		check_word("cfg", d[cnt_w-1:0], 16'h0021);
		finish_test("reset");

		// All funct3 values with bit 30 clear and set, immediate and register forms
		for (int k = 0; k < 32; k++)
			send(enc(k[4] ? OPC_OP : OPC_OP_IMM, 5'd10, 5'd1, 5'd2, k[2:0],
				{1'b0, k[3], 5'b0}), 0, 1'b0);
		send(enc(OPC_LUI, 5'd11, 5'd0, 5'd0, 3'd0, 7'd0), 0, 1'b0);
		send(enc(OPC_AUIPC, 5'd12, 5'd0, 5'd0, 3'd0, 7'd0), 0, 1'b0);
		send(enc(OPC_JAL, 5'd13, 5'd0, 5'd0, 3'd0, 7'd0), 0, 1'b0);
		send(enc(OPC_JALR, 5'd14, 5'd1, 5'd0, 3'd0, 7'd0), 0, 1'b0);
		send(enc(OPC_BRANCH, 5'd3, 5'd1, 5'd2, 3'd0, 7'd0), 0, 1'b0);
		send(enc(OPC_LOAD, 5'd15, 5'd1, 5'd0, 3'd2, 7'd0), 0, 1'b0);
		send(enc(OPC_STORE, 5'd4, 5'd2, 5'd1, 3'd2, 7'd0), 0, 1'b0);
		send(enc(OPC_FENCE, 5'd0, 5'd0, 5'd0, 3'd0, 7'd0), 0, 1'b0);
		idle(3);
		finish_test("decode");

		hazard_pair(enc(OPC_LOAD, 5'd5, 5'd1, 5'd0, 3'd2, 7'd0),
			enc(OPC_OP, 5'd6, 5'd5, 5'd2, 3'd0, 7'd0), 1);
		hazard_pair(enc(OPC_OP_IMM, 5'd7, 5'd1, 5'd0, 3'd0, 7'd0),
			enc(OPC_BRANCH, 5'd0, 5'd7, 5'd2, 3'd0, 7'd0), 1);
		hazard_pair(enc(OPC_LOAD, 5'd0, 5'd1, 5'd0, 3'd2, 7'd0),
			enc(OPC_OP, 5'd3, 5'd0, 5'd2, 3'd0, 7'd0), 0);
		finish_test("load-use and writer-branch");

		axi_write(CFG_ADDR, 32'h11);
		hazard_pair(enc(OPC_LOAD, 5'd5, 5'd1, 5'd0, 3'd2, 7'd0),
			enc(OPC_BRANCH, 5'd0, 5'd5, 5'd2, 3'd0, 7'd0), 1);
		axi_write(CFG_ADDR, 32'h41);
		hazard_pair(enc(OPC_LOAD, 5'd5, 5'd1, 5'd0, 3'd2, 7'd0),
			enc(OPC_BRANCH, 5'd0, 5'd5, 5'd2, 3'd0, 7'd0), 4);
		axi_write(CFG_ADDR, 32'h40);
		hazard_pair(enc(OPC_LOAD, 5'd5, 5'd1, 5'd0, 3'd2, 7'd0),
			enc(OPC_BRANCH, 5'd0, 5'd5, 5'd2, 3'd0, 7'd0), 0);
		hazard_pair(enc(OPC_LOAD, 5'd5, 5'd1, 5'd0, 3'd2, 7'd0),
			enc(OPC_OP, 5'd6, 5'd5, 5'd2, 3'd0, 7'd0), 0);
		axi_write(CFG_ADDR, 32'h21);
		finish_test("load-branch");

		send(enc(OPC_OP, 5'd8, 5'd1, 5'd2, 3'd4, 7'd0), 0, 1'b0);
		send(enc(OPC_OP, 5'd9, 5'd1, 5'd2, 3'd6, 7'd0), 0, 1'b1);
		send(enc(OPC_OP_IMM, 5'd10, 5'd1, 5'd0, 3'd7, 7'd0), 5, 1'b0);
		send(enc(OPC_LOAD, 5'd11, 5'd1, 5'd0, 3'd2, 7'd0), 3, 1'b0);
		idle(3);
		finish_test("flush and stall");

		axi_write(BUBBLE_CNT_ADDR, 32'h0);
		axi_write(STALL_CYC_ADDR, 32'h0);
		bub_base = m_bub;
		stl_base = m_stl;
		repeat (200) begin
			n = ($unsigned($random(seed)) % 8 == 0) ? 1 + $unsigned($random(seed)) % 3 : 0;
			send(rand_instr(), n, 1'b0);
		end
		idle(3);
		axi_read(BUBBLE_CNT_ADDR, d);
		check_word("bubble_cnt", d[cnt_w-1:0], cnt_w'(m_bub - bub_base));
		axi_read(STALL_CYC_ADDR, d);
		check_word("stall_cyc", d[cnt_w-1:0], cnt_w'(m_stl - stl_base));
		axi_write(BUBBLE_CNT_ADDR, 32'h0);
		axi_write(STALL_CYC_ADDR, 32'h0);
		axi_read(BUBBLE_CNT_ADDR, d);
		check_word("bubble_cnt", d[cnt_w-1:0], '0);
		axi_read(STALL_CYC_ADDR, d);
		check_word("stall_cyc", d[cnt_w-1:0], '0);
		axi_read(4'hc, d);
		check_word("unmapped", d[cnt_w-1:0], '0);
		finish_test("counters");

		$display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/cu_pkg.sv
logic/instr_decode.sv
logic/hazard_unit.sv
logic/ctrl_pipe.sv
logic/cu_csr.sv
logic/cu_top.sv
verif/cu_tb.sv
